// File: fetch_frontend.f
design/frontend_pkg.sv
design/pc_gen.sv
design/fetch_align.sv
design/instr_buffer.sv
design/fetch_frontend.sv
testbench/tb_icache_model.sv
testbench/tb_fetch_frontend.sv

// File: Makefile
TOP   := tb_fetch_frontend
FLIST := fetch_frontend.f

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f $(FLIST) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

// File: testbench/tb_fetch_frontend.sv
module tb_fetch_frontend;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int xlen = frontend_pkg::xlen;
  localparam logic [31:0] word_pattern = 32'h5a5a0000;
  localparam int pop_target = 4000;
  // slowest mix retires about one instruction per five cycles
  localparam int cycle_limit = pop_target * 5;

  logic                                     aclk = 1'b0;
  logic                                     reset;
  logic                                     redirect;
  logic [xlen-1:0]                          redirect_pc;
  logic                                     fetch_ready;
  logic                                     fetch_rvalid;
  logic [frontend_pkg::line_width-1:0]      fetch_rdata;
  logic [frontend_pkg::pop_count_width-1:0] pop_count;
  logic                                     fetch_valid;
  logic [xlen-1:0]                          fetch_addr;
  logic                                     instr0_valid;
  logic [xlen-1:0]                          instr0_pc;
  logic [xlen-1:0]                          instr0_word;
  logic                                     instr1_valid;
  logic [xlen-1:0]                          instr1_pc;
  logic [xlen-1:0]                          instr1_word;

  logic [xlen-1:0] exp_pc;
  logic [xlen-1:0] last_addr;
  logic [1:0]      popped;
  integer          seed;
  int              pause_left;
  int              pops_done = 0;
  int              full_cycles = 0;
  int              redirects = 0;
  int              cycles = 0;

  always #4 aclk = ~aclk;

  fetch_frontend UUT (
    .aclk           (aclk),
    .i_reset        (reset),
    .i_redirect     (redirect),
    .i_redirect_pc  (redirect_pc),
    .i_fetch_ready  (fetch_ready),
    .i_fetch_rvalid (fetch_rvalid),
    .i_fetch_rdata  (fetch_rdata),
    .i_pop_count    (pop_count),
    .o_fetch_valid  (fetch_valid),
    .o_fetch_addr   (fetch_addr),
    .o_instr0_valid (instr0_valid),
    .o_instr0_pc    (instr0_pc),
    .o_instr0_word  (instr0_word),
    .o_instr1_valid (instr1_valid),
    .o_instr1_pc    (instr1_pc),
    .o_instr1_word  (instr1_word)
  );

  tb_icache_model #(.word_pattern(word_pattern)) u_icache (
    .aclk           (aclk),
    .i_reset        (reset),
    .i_fetch_valid  (fetch_valid),
    .i_fetch_addr   (fetch_addr),
    .o_fetch_ready  (fetch_ready),
    .o_fetch_rvalid (fetch_rvalid),
    .o_fetch_rdata  (fetch_rdata)
  );

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
    $display("Simulation failed");
    $fatal(1, "value check failed");
  endtask

  // instructions retired at this edge
  assign popped = {1'b0, pop_count != 2'd0 && instr0_valid} +
                  {1'b0, pop_count == 2'd2 && instr1_valid};

  // expected program order
  always @(posedge aclk) begin
    last_addr <= fetch_addr;
    if (reset) begin
      exp_pc <= frontend_pkg::reset_pc;
      pops_done <= 0;
    end else if (redirect) begin
      exp_pc <= redirect_pc;
      redirects <= redirects + 1;
    end else begin
      exp_pc <= exp_pc + {28'd0, popped, 2'b00};
      pops_done <= pops_done + int'(popped);
    end
    if (!reset && UUT.free_slots < 5'd4) begin
      full_cycles <= full_cycles + 1;
    end
  end

  always @(posedge aclk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: %0d of %0d pops after %0d cycles", pops_done, pop_target, cycles);
      $display("Simulation failed");
      $fatal(1, "run did not finish");
    end
  end

  assert property (@(posedge aclk) reset |=> !fetch_valid)
    else report_mismatch("o_fetch_valid", 32'($sampled(fetch_valid)), 32'd0);
  assert property (@(posedge aclk) reset |=> !instr0_valid)
    else report_mismatch("o_instr0_valid", 32'($sampled(instr0_valid)), 32'd0);
  assert property (@(posedge aclk) reset |=> !instr1_valid)
    else report_mismatch("o_instr1_valid", 32'($sampled(instr1_valid)), 32'd0);

  assert property (@(posedge aclk) disable iff (reset) instr0_valid |-> instr0_pc == exp_pc)
    else report_mismatch("o_instr0_pc", $sampled(instr0_pc), $sampled(exp_pc));
  assert property (@(posedge aclk) disable iff (reset)
                   instr0_valid |-> instr0_word == (exp_pc ^ word_pattern))
    else report_mismatch("o_instr0_word", $sampled(instr0_word),
                         $sampled(exp_pc) ^ word_pattern);
  assert property (@(posedge aclk) disable iff (reset) instr1_valid |-> instr0_valid)
    else report_mismatch("o_instr0_valid", 32'($sampled(instr0_valid)), 32'd1);
  assert property (@(posedge aclk) disable iff (reset)
                   instr1_valid |-> instr1_pc == exp_pc + 32'd4)
    else report_mismatch("o_instr1_pc", $sampled(instr1_pc), $sampled(exp_pc) + 32'd4);
  assert property (@(posedge aclk) disable iff (reset)
                   instr1_valid |-> instr1_word == ((exp_pc + 32'd4) ^ word_pattern))
    else report_mismatch("o_instr1_word", $sampled(instr1_word),
                         ($sampled(exp_pc) + 32'd4) ^ word_pattern);

  // waiting request holds until taken
  assert property (@(posedge aclk) disable iff (reset)
                   fetch_valid && !fetch_ready |=> redirect || fetch_valid)
    else report_mismatch("o_fetch_valid", 32'($sampled(fetch_valid)), 32'd1);
  assert property (@(posedge aclk) disable iff (reset)
                   fetch_valid && !fetch_ready |=> redirect || fetch_addr == last_addr)
    else report_mismatch("o_fetch_addr", $sampled(fetch_addr), $sampled(last_addr));
  assert property (@(posedge aclk) disable iff (reset) fetch_valid |-> fetch_addr[3:0] == 4'd0)
    else report_mismatch("o_fetch_addr", $sampled(fetch_addr), $sampled(fetch_addr) & ~32'hf);
  assert property (@(posedge aclk) disable iff (reset) UUT.free_slots < 5'd4 |-> !fetch_valid)
    else report_mismatch("o_fetch_valid", 32'($sampled(fetch_valid)), 32'd0);

  assert property (@(posedge aclk) disable iff (reset) redirect |=> !instr0_valid)
    else report_mismatch("o_instr0_valid", 32'($sampled(instr0_valid)), 32'd0);
  assert property (@(posedge aclk) disable iff (reset) redirect |=> !instr1_valid)
    else report_mismatch("o_instr1_valid", 32'($sampled(instr1_valid)), 32'd0);

  initial begin
    seed = 77524;
    reset = 1'b1;
    redirect = 1'b0;
    redirect_pc = '0;
    pop_count = '0;
    pause_left = 0;
    repeat (16) @(posedge aclk);
    #1;
    reset = 1'b0;
    while (pops_done < pop_target) begin
      @(posedge aclk);
      #1;
      redirect = 1'b0;
      if (pause_left > 0) begin
        pause_left--;
        pop_count = '0;
      end else if ({$random(seed)} % 200 == 0) begin
        // long stall lets the buffer fill
        pause_left = 40 + int'({$random(seed)} % 60);
        pop_count = '0;
      end else begin
        pop_count = frontend_pkg::pop_count_width'({$random(seed)} % 3);
      end
      if (cycles > 200 && {$random(seed)} % 64 == 0) begin
        redirect = 1'b1;
        redirect_pc = {$random(seed)} & 32'hffff_fffc;
      end
    end
    if (full_cycles == 0 || redirects == 0) begin
      $display("stimulus never filled the buffer or never sent a redirect");
      $display("Simulation failed");
      $fatal(1, "stimulus incomplete");
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

// File: testbench/tb_icache_model.sv
module tb_icache_model #(
  parameter logic [31:0] word_pattern = 32'h0
) (
  input  logic                                aclk,
  input  logic                                i_reset,
  input  logic                                i_fetch_valid,
  input  logic [frontend_pkg::xlen-1:0]       i_fetch_addr,
  output logic                                o_fetch_ready,
  output logic                                o_fetch_rvalid,
  output logic [frontend_pkg::line_width-1:0] o_fetch_rdata
);
  timeunit 1ns;
  timeprecision 100ps;

  integer      seed;
  int          cycle;
  logic        in_reset;
  logic        took;
  logic [31:0] took_addr;
  logic [31:0] line_addr;
  logic [31:0] addr_q [$];
  int          due_q [$];

  initial begin
    seed = 77524;
    cycle = 0;
    o_fetch_ready = 1'b0;
    o_fetch_rvalid = 1'b0;
    o_fetch_rdata = '0;
    forever begin
      @(posedge aclk);
      // handshake as seen at the edge
      in_reset = i_reset;
      took = i_fetch_valid && o_fetch_ready;
      took_addr = i_fetch_addr;
      cycle++;
      #1;
      if (in_reset) begin
        addr_q.delete();
        due_q.delete();
        o_fetch_ready = 1'b0;
        o_fetch_rvalid = 1'b0;
      end else begin
        if (took) begin
          addr_q.push_back(took_addr);
          // answer 1 to 4 cycles after acceptance
          due_q.push_back(cycle + int'({$random(seed)} % 4));
        end
        o_fetch_rvalid = 1'b0;
        if (due_q.size() > 0 && due_q[0] <= cycle) begin
          line_addr = addr_q.pop_front();
          void'(due_q.pop_front());
          o_fetch_rvalid = 1'b1;
          for (int k = 0; k < frontend_pkg::fetch_width; k++) begin
            o_fetch_rdata[k*32 +: 32] = (line_addr + 32'(k * 4)) ^ word_pattern;
          end
        end
        o_fetch_ready = ({$random(seed)} % 4) != 0;
      end
    end
  end

endmodule

// File: design/fetch_frontend.sv
module fetch_frontend (
  input  logic                                      aclk,
  input  logic                                      i_reset,
  input  logic                                      i_redirect,
  input  logic [frontend_pkg::xlen-1:0]             i_redirect_pc,
  input  logic                                      i_fetch_ready,
  input  logic                                      i_fetch_rvalid,
  input  logic [frontend_pkg::line_width-1:0]       i_fetch_rdata,
  input  logic [frontend_pkg::pop_count_width-1:0]  i_pop_count,
  output logic                                      o_fetch_valid,
  output logic [frontend_pkg::xlen-1:0]             o_fetch_addr,
  output logic                                      o_instr0_valid,
  output logic [frontend_pkg::xlen-1:0]             o_instr0_pc,
  output logic [frontend_pkg::xlen-1:0]             o_instr0_word,
  output logic                                      o_instr1_valid,
  output logic [frontend_pkg::xlen-1:0]             o_instr1_pc,
  output logic [frontend_pkg::xlen-1:0]             o_instr1_word
);

  logic [frontend_pkg::xlen-1:0]                   req_pc;
  logic                                            if1_ready;
  logic [frontend_pkg::ib_count_width-1:0]         free_slots;
  logic [frontend_pkg::push_count_width-1:0]       push_count;
  logic [frontend_pkg::fetch_width*frontend_pkg::xlen-1:0] push_pc;
  logic [frontend_pkg::fetch_width*frontend_pkg::xlen-1:0] push_word;

  // fetch stage 0
  pc_gen u_pc_gen (
    .aclk          (aclk),
    .i_reset       (i_reset),
    .i_redirect    (i_redirect),
    .i_redirect_pc (i_redirect_pc),
    .i_fetch_ready (i_fetch_ready),
    .i_if1_ready   (if1_ready),
    .i_free_slots  (free_slots),
    .o_fetch_valid (o_fetch_valid),
    .o_fetch_addr  (o_fetch_addr),
    .o_req_pc      (req_pc)
  );

  // fetch stage 1
  fetch_align u_fetch_align (
    .aclk           (aclk),
    .i_reset        (i_reset),
    .i_redirect     (i_redirect),
    .i_fetch_valid  (o_fetch_valid),
    .i_fetch_ready  (i_fetch_ready),
    .i_req_pc       (req_pc),
    .i_fetch_rvalid (i_fetch_rvalid),
    .i_fetch_rdata  (i_fetch_rdata),
    .o_if1_ready    (if1_ready),
    .o_push_count   (push_count),
    .o_push_pc      (push_pc),
    .o_push_word    (push_word)
  );

  instr_buffer u_instr_buffer (
    .aclk           (aclk),
    .i_reset        (i_reset),
    .i_flush        (i_redirect),
    .i_push_count   (push_count),
    .i_push_pc      (push_pc),
    .i_push_word    (push_word),
    .i_pop_count    (i_pop_count),
    .o_free_slots   (free_slots),
    .o_instr0_valid (o_instr0_valid),
    .o_instr0_pc    (o_instr0_pc),
    .o_instr0_word  (o_instr0_word),
    .o_instr1_valid (o_instr1_valid),
    .o_instr1_pc    (o_instr1_pc),
    .o_instr1_word  (o_instr1_word)
  );

endmodule

// File: design/instr_buffer.sv
module instr_buffer (
  input  logic                                          aclk,
  input  logic                                          i_reset,
  input  logic                                          i_flush,
  input  logic [frontend_pkg::push_count_width-1:0]     i_push_count,
  input  logic [frontend_pkg::fetch_width*frontend_pkg::xlen-1:0] i_push_pc,
  input  logic [frontend_pkg::fetch_width*frontend_pkg::xlen-1:0] i_push_word,
  input  logic [frontend_pkg::pop_count_width-1:0]      i_pop_count,
  output logic [frontend_pkg::ib_count_width-1:0]       o_free_slots,
  output logic                                          o_instr0_valid,
  output logic [frontend_pkg::xlen-1:0]                 o_instr0_pc,
  output logic [frontend_pkg::xlen-1:0]                 o_instr0_word,
  output logic                                          o_instr1_valid,
  output logic [frontend_pkg::xlen-1:0]                 o_instr1_pc,
  output logic [frontend_pkg::xlen-1:0]                 o_instr1_word
);

  localparam int xlen = frontend_pkg::xlen;
  localparam int ptr_w = frontend_pkg::ib_ptr_width;
  localparam int cnt_w = frontend_pkg::ib_count_width;

  logic [xlen-1:0]  mem_pc   [frontend_pkg::ib_depth];
  logic [xlen-1:0]  mem_word [frontend_pkg::ib_depth];

  logic [ptr_w-1:0] head_q;
  logic [ptr_w-1:0] tail_q;
  logic [cnt_w-1:0] count_q;
  logic [ptr_w-1:0] head_next;
  logic [frontend_pkg::pop_count_width-1:0] pop_num;

  // never retire more than is held
  always_comb begin
    if (cnt_w'(i_pop_count) > count_q) begin
      pop_num = count_q[frontend_pkg::pop_count_width-1:0];
    end else begin
      pop_num = i_pop_count;
    end
  end

  always_ff @(posedge aclk) begin
    if (i_reset || i_flush) begin
      head_q <= '0;
      tail_q <= '0;
      count_q <= '0;
    end else begin
      tail_q <= tail_q + ptr_w'(i_push_count);
      head_q <= head_q + ptr_w'(pop_num);
      count_q <= count_q + cnt_w'(i_push_count) - cnt_w'(pop_num);
    end
  end

  // consecutive entries from the tail with the pointer wrapping on its own
  always_ff @(posedge aclk) begin
    if (!i_flush) begin
      for (int k = 0; k < frontend_pkg::fetch_width; k++) begin
        if (k < int'(i_push_count)) begin
          mem_pc[tail_q + ptr_w'(k)] <= i_push_pc[k*xlen +: xlen];
          mem_word[tail_q + ptr_w'(k)] <= i_push_word[k*xlen +: xlen];
        end
      end
    end
  end

  assign o_free_slots = cnt_w'(frontend_pkg::ib_depth) - count_q;

  assign head_next = head_q + ptr_w'(1);

  assign o_instr0_valid = count_q != '0;
  assign o_instr0_pc = mem_pc[head_q];
  assign o_instr0_word = mem_word[head_q];

  // second slot only when two are held
  assign o_instr1_valid = count_q > cnt_w'(1);
  assign o_instr1_pc = mem_pc[head_next];
  assign o_instr1_word = mem_word[head_next];

endmodule

// File: design/fetch_align.sv
module fetch_align (
  input  logic                                          aclk,
  input  logic                                          i_reset,
  input  logic                                          i_redirect,
  input  logic                                          i_fetch_valid,
  input  logic                                          i_fetch_ready,
  input  logic [frontend_pkg::xlen-1:0]                 i_req_pc,
  input  logic                                          i_fetch_rvalid,
  input  logic [frontend_pkg::line_width-1:0]           i_fetch_rdata,
  output logic                                          o_if1_ready,
  output logic [frontend_pkg::push_count_width-1:0]     o_push_count,
  output logic [frontend_pkg::fetch_width*frontend_pkg::xlen-1:0] o_push_pc,
  output logic [frontend_pkg::fetch_width*frontend_pkg::xlen-1:0] o_push_word
);

  localparam int xlen = frontend_pkg::xlen;
  localparam int lo_w = frontend_pkg::line_offset_width;
  localparam int sel_w = frontend_pkg::slot_sel_width;

  logic                  pending_q;
  logic                  kill_q;
  logic [xlen-1:0]       line_base_q;
  logic [sel_w-1:0]      offset_q;
  logic                  accept;
  logic                  deliver;

  assign accept = i_fetch_valid && i_fetch_ready;
  assign o_if1_ready = !pending_q;

  // a redirect in the return cycle kills the line as well
  assign deliver = i_fetch_rvalid && pending_q && !kill_q && !i_redirect;

  assign o_push_count = deliver ?
      frontend_pkg::push_count_width'(frontend_pkg::fetch_width) -
      frontend_pkg::push_count_width'(offset_q) :
      '0;

  always_ff @(posedge aclk) begin
    if (i_reset) begin
      pending_q <= 1'b0;
      kill_q <= 1'b0;
    end else if (accept) begin
      pending_q <= 1'b1;
      kill_q <= 1'b0;
    end else if (i_fetch_rvalid) begin
      pending_q <= 1'b0;
      kill_q <= 1'b0;
    end else if (i_redirect && pending_q) begin
      kill_q <= 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (accept) begin
      line_base_q <= {i_req_pc[xlen-1:lo_w], {lo_w{1'b0}}};
      offset_q <= i_req_pc[lo_w-1:lo_w-sel_w];
    end
  end

  // slot 0 of the push holds the requested pc
  always_comb begin
    o_push_pc = '0;
    o_push_word = '0;
    for (int k = 0; k < frontend_pkg::fetch_width; k++) begin
      if (k + int'(offset_q) < frontend_pkg::fetch_width) begin
        o_push_word[k*xlen +: xlen] = i_fetch_rdata[(k + int'(offset_q))*xlen +: xlen];
        o_push_pc[k*xlen +: xlen] = line_base_q +
                                    (xlen'(k + int'(offset_q)) << 2);
      end
    end
  end

endmodule

// File: design/pc_gen.sv
module pc_gen (
  input  logic                                  aclk,
  input  logic                                  i_reset,
  input  logic                                  i_redirect,
  input  logic [frontend_pkg::xlen-1:0]         i_redirect_pc,
  input  logic                                  i_fetch_ready,
  input  logic                                  i_if1_ready,
  input  logic [frontend_pkg::ib_count_width-1:0] i_free_slots,
  output logic                                  o_fetch_valid,
  output logic [frontend_pkg::xlen-1:0]         o_fetch_addr,
  output logic [frontend_pkg::xlen-1:0]         o_req_pc
);

  logic [frontend_pkg::xlen-1:0] pc_q;
  logic                          run_q;
  logic                          room_ok;
  logic                          accept;
  logic [frontend_pkg::xlen-1:0] next_line;

  // a full line must fit in the buffer before asking for one
  assign room_ok = i_free_slots >=
                   frontend_pkg::ib_count_width'(frontend_pkg::fetch_width);

  // held low until the first cycle out of reset
  assign o_fetch_valid = run_q && i_if1_ready && room_ok && !i_redirect;
  assign accept = o_fetch_valid && i_fetch_ready;

  assign o_fetch_addr = {pc_q[frontend_pkg::xlen-1:frontend_pkg::line_offset_width],
                         {frontend_pkg::line_offset_width{1'b0}}};
  assign o_req_pc = pc_q;

  assign next_line = o_fetch_addr +
                     (frontend_pkg::xlen'(1) << frontend_pkg::line_offset_width);

  always_ff @(posedge aclk) begin
    if (i_reset) begin
      run_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (i_reset) begin
      pc_q <= frontend_pkg::reset_pc;
    end else if (i_redirect) begin
      pc_q <= i_redirect_pc;
    end else if (accept) begin
      // step to the start of the following line
      pc_q <= next_line;
    end
  end

endmodule

// File: design/frontend_pkg.sv
package frontend_pkg;

  // datapath widths
  localparam int xlen = 32;
  localparam int fetch_width = 4;
  localparam int line_width = fetch_width * xlen;

  // pc bits 3:2 pick the slot, bits 3:0 are cleared on a request
  localparam int slot_sel_width = 2;
  localparam int line_offset_width = 4;

  // instruction buffer sizing
  localparam int ib_depth = 16;
  localparam int ib_ptr_width = 4;
  localparam int ib_count_width = 5;

  // push 0..4, pop 0..2
  localparam int push_count_width = 3;
  localparam int pop_count_width = 2;

  localparam logic [xlen-1:0] reset_pc = 32'h1c000000;

endpackage
